// File: build.f
+incdir+.
mul_pkg.sv
fifo_sync.sv
mul_seq.sv
mul_datapath.sv
mul_top.sv
mul_asserts.sv
mul_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mul_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv *.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: mul_tb.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_tb import mul_pkg::*; ();

  localparam int PROD_W = 2 * `MUL_OP_W;

  logic                     clk;
  logic                     reset;
  op_push_t                 op_a;
  op_push_t                 op_b;
  seq_ctrl_t                ctrl;
  logic                     res_pop;
  logic [PROD_W-1:0]        res_data;
  logic                     res_valid;
  logic [`MUL_OP_CNT_W-1:0] op_count_a;
  logic [`MUL_OP_CNT_W-1:0] op_count_b;
  mul_state_e               state;

  // model of the sequencer and fifos
  mul_state_e        m_state;
  int                m_step;
  int                m_rc;
  bit                m_inflight;
  logic [31:0]       qa[$];
  logic [31:0]       qb[$];
  logic [PROD_W-1:0] exp_q[$];
  logic [31:0]       lfsr;
  bit                checking;
  bit                read_en;
  int                received;
  int                loops;

  mul_top mul_top_i (
    .clk        (clk),
    .reset      (reset),
    .op_a       (op_a),
    .op_b       (op_b),
    .ctrl       (ctrl),
    .res_pop    (res_pop),
    .res_data   (res_data),
    .res_valid  (res_valid),
    .op_count_a (op_count_a),
    .op_count_b (op_count_b),
    .state      (state)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // unsigned product by shift and add
  function automatic logic [PROD_W-1:0] ref_product(input logic [31:0] a, input logic [31:0] b);
    logic [PROD_W-1:0] acc;
    acc = '0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) acc = acc + ({32'b0, a} << i);
    end
    return acc;
  endfunction

  // galois lfsr, one step per bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_product(input logic [PROD_W-1:0] got, input logic [PROD_W-1:0] exp,
                               input string name);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      report_fail("product mismatch");
    end
  endtask

  task automatic check_state(input mul_state_e got, input mul_state_e exp, input string name);
    if (got !== exp) begin
      $display("ERR %0t %s got %s expected %s", $time, name, got.name(), exp.name());
      report_fail("state mismatch");
    end
  endtask

  task automatic check_count(input logic [`MUL_OP_CNT_W-1:0] got,
                             input logic [`MUL_OP_CNT_W-1:0] exp, input string name);
    if (got !== exp) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      report_fail("count mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      report_fail("flag mismatch");
    end
  endtask

  // reference sequencer, reads only tb-driven inputs
  always @(posedge clk) begin
    int  pend;
    bit  adv;
    bit  iss;
    int  sa;
    int  sb;
    if (reset) begin
      m_state    = IDLE;
      m_step     = 0;
      m_rc       = 0;
      m_inflight = 0;
      qa.delete();
      qb.delete();
      exp_q.delete();
    end else begin
      pend = m_rc + m_inflight;
      adv  = pend < `MUL_RES_DEPTH;
      sa   = qa.size();
      sb   = qb.size();
      iss  = (m_state == EXEC) && !ctrl.clear && adv && sa != 0 && sb != 0;
      if (iss) begin
        exp_q.push_back(ref_product(qa[0], qb[0]));
        void'(qa.pop_front());
        void'(qb.pop_front());
      end
      if (op_a.push && sa < `MUL_OP_DEPTH) qa.push_back(op_a.data);
      if (op_b.push && sb < `MUL_OP_DEPTH) qb.push_back(op_b.data);
      m_rc = m_rc + m_inflight - ((res_pop && m_rc != 0) ? 1 : 0);
      m_inflight = iss;
      if (ctrl.clear) begin
        m_state = IDLE;
        m_step  = 0;
      end else begin
        case (m_state)
          IDLE: m_state = ctrl.start ? EXEC : IDLE;
          EXEC: begin
            if (adv) begin
              if (m_step == `MUL_STEPS - 1) m_state = OUT;
              m_step = m_step + 1;
            end
          end
          OUT: m_state = (sa == 0 && sb == 0) ? DONE : IDLE;
          default: m_state = ctrl.start ? DONE : IDLE;
        endcase
        if (m_state != EXEC) m_step = 0;
      end
    end
  end

  // per-cycle compare against the model
  always @(negedge clk) begin
    if (checking) begin
      check_state(state, m_state, "state");
      check_count(op_count_a, `MUL_OP_CNT_W'(qa.size()), "op_count_a");
      check_count(op_count_b, `MUL_OP_CNT_W'(qb.size()), "op_count_b");
      check_flag(res_valid, m_rc != 0, "res_valid");
    end
  end

  // result reader
  always @(posedge clk) begin
    #1;
    if (!reset && read_en && res_valid) begin
      if (exp_q.size() == 0) report_fail("result fifo holds a product that was never issued");
      check_product(res_data, exp_q.pop_front(), "res_data");
      received++;
      res_pop = 1'b1;
    end else begin
      res_pop = 1'b0;
    end
  end

  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
    return w;
  endfunction

  task automatic push_pair();
    op_a.push = 1'b1;
    op_a.data = rand_word();
    op_b.push = 1'b1;
    op_b.data = rand_word();
    step_cycle();
    op_a.push = 1'b0;
    op_b.push = 1'b0;
  endtask

  task automatic pulse_start();
    ctrl.start = 1'b1;
    step_cycle();
    ctrl.start = 1'b0;
  endtask

  task automatic wait_state(input mul_state_e target, input int limit);
    int n;
    n = 0;
    while (state !== target) begin
      if (n >= limit) report_fail($sformatf("timed out waiting for state %s", target.name()));
      step_cycle();
      n++;
    end
  endtask

  task automatic wait_received(input int total, input int limit);
    int n;
    n = 0;
    while (received < total) begin
      if (n >= limit) report_fail($sformatf("only %0d of %0d products arrived", received, total));
      step_cycle();
      n++;
    end
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 || res_valid || m_inflight) begin
      if (n >= limit) report_fail("issued products were not all delivered");
      step_cycle();
      n++;
    end
  endtask

  task automatic wait_exec_end(input int limit);
    int n;
    n = 0;
    while (state == EXEC && (m_rc + m_inflight) < `MUL_RES_DEPTH) begin
      if (n >= limit) report_fail("EXEC did not end or stall");
      step_cycle();
      n++;
    end
  endtask

  initial begin
    reset    = 1'b1;
    op_a     = '0;
    op_b     = '0;
    ctrl     = '0;
    res_pop  = 1'b0;
    read_en  = 1'b1;
    checking = 1'b0;
    received = 0;
    lfsr     = 32'h6edee7d1;
    repeat (16) @(posedge clk);
    #1;
    reset    = 1'b0;
    checking = 1'b1;
    step_cycle();

    // products in push order
    repeat (4) push_pair();
    pulse_start();
    wait_received(4, 100);
    wait_state(IDLE, 20);

    // step limit, then the rest of the words
    repeat (6) push_pair();
    pulse_start();
    wait_received(8, 100);
    wait_state(IDLE, 20);
    check_count(op_count_a, 4'd2, "op_count_a");
    check_count(op_count_b, 4'd2, "op_count_b");
    push_pair();
    ctrl.start = 1'b1;  // held through DONE
    step_cycle();
    wait_state(DONE, 100);
    repeat (5) begin
      step_cycle();
      check_state(state, DONE, "state");
    end
    ctrl.start = 1'b0;
    wait_state(IDLE, 10);
    wait_received(11, 100);

    // clear in the middle of EXEC
    repeat (8) push_pair();
    pulse_start();
    wait_state(EXEC, 10);
    step_cycle();
    ctrl.clear = 1'b1;
    step_cycle();
    ctrl.clear = 1'b0;
    check_state(state, IDLE, "state");
    wait_drain(100);
    repeat (10) step_cycle();
    if (op_count_a == '0) report_fail("clear lost the remaining operand words");

    // back-pressure with reading stopped
    read_en = 1'b0;
    loops   = 0;
    while (!(state == EXEC && (m_rc + m_inflight) >= `MUL_RES_DEPTH)) begin
      if (loops >= 10) report_fail("result fifo never filled up");
      while (qa.size() < `MUL_OP_DEPTH) push_pair();
      pulse_start();
      wait_exec_end(50);
      if (state != EXEC) wait_state(IDLE, 10);
      loops++;
    end
    repeat (10) begin
      step_cycle();
      check_state(state, EXEC, "state");
      if (!res_valid) report_fail("res_valid dropped during the stall");
    end
    read_en = 1'b1;
    wait_state(IDLE, 100);
    wait_drain(200);

    $display("Regression passed");
    $finish;
  end

  // whole-run limit
  initial begin
    #200us;
    report_fail("simulation ran past its time limit");
  end

endmodule

// File: mul_asserts.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_asserts import mul_pkg::*; (
  input logic                     clk,
  input logic                     reset,
  input seq_ctrl_t                ctrl,
  input logic [`MUL_OP_CNT_W-1:0] count_a,
  input logic [`MUL_OP_CNT_W-1:0] count_b,
  input mul_state_e               state,
  input logic                     issue
);

  issue_in_exec: assert property (@(posedge clk) disable iff (reset)
    issue |-> state == EXEC)
    else $error("issue outside EXEC");

  clear_to_idle: assert property (@(posedge clk) disable iff (reset)
    ctrl.clear |=> state == IDLE)
    else $error("clear did not return to IDLE");

  // a normal exit from EXEC needs four slots behind it
  exec_min_len: assert property (@(posedge clk) disable iff (reset)
    (state != EXEC && $past(state) == EXEC && !$past(ctrl.clear) && !$past(reset))
    |-> ($past(state, 2) == EXEC && $past(state, 3) == EXEC && $past(state, 4) == EXEC))
    else $error("EXEC shorter than four cycles");

  issue_needs_ops: assert property (@(posedge clk) disable iff (reset)
    issue |-> (count_a != '0 && count_b != '0))
    else $error("issue with an empty operand fifo");

endmodule

bind mul_seq mul_asserts mul_asserts_i (
  .clk     (clk),
  .reset   (reset),
  .ctrl    (ctrl),
  .count_a (count_a),
  .count_b (count_b),
  .state   (state),
  .issue   (issue)
);

// File: mul_top.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_top import mul_pkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  op_push_t                 op_a,
  input  op_push_t                 op_b,
  input  seq_ctrl_t                ctrl,
  input  logic                     res_pop,
  output logic [2*`MUL_OP_W-1:0]   res_data,
  output logic                     res_valid,
  output logic [`MUL_OP_CNT_W-1:0] op_count_a,
  output logic [`MUL_OP_CNT_W-1:0] op_count_b,
  output mul_state_e               state
);

  logic [`MUL_OP_W-1:0]      head_a;
  logic [`MUL_OP_W-1:0]      head_b;
  logic [`MUL_RES_CNT_W-1:0] res_count;
  logic                      issue;
  res_push_t                 res;

  // operand a
  fifo_sync #(
    .WIDTH (`MUL_OP_W),
    .DEPTH (`MUL_OP_DEPTH)
  ) fifo_a (
    .clk   (clk),
    .reset (reset),
    .push  (op_a.push),
    .wdata (op_a.data),
    .pop   (issue),       // both fifos pop together
    .rdata (head_a),
    .count (op_count_a)
  );

  // operand b
  fifo_sync #(
    .WIDTH (`MUL_OP_W),
    .DEPTH (`MUL_OP_DEPTH)
  ) fifo_b (
    .clk   (clk),
    .reset (reset),
    .push  (op_b.push),
    .wdata (op_b.data),
    .pop   (issue),
    .rdata (head_b),
    .count (op_count_b)
  );

  mul_seq mul_seq_i (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl),
    .count_a      (op_count_a),
    .count_b      (op_count_b),
    .res_count    (res_count),
    .res_inflight (res.push),
    .state        (state),
    .issue        (issue)
  );

  mul_datapath mul_datapath_i (
    .clk   (clk),
    .reset (reset),
    .clear (ctrl.clear),
    .issue (issue),
    .a     (head_a),
    .b     (head_b),
    .res   (res)
  );

  // products waiting for the host
  fifo_sync #(
    .WIDTH (2 * `MUL_OP_W),
    .DEPTH (`MUL_RES_DEPTH)
  ) fifo_res (
    .clk   (clk),
    .reset (reset),
    .push  (res.push),
    .wdata (res.product),
    .pop   (res_pop),
    .rdata (res_data),
    .count (res_count)
  );

  assign res_valid = (res_count != '0);  // rises a cycle after the push

endmodule

// File: mul_datapath.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_datapath import mul_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clear,
  input  logic                 issue,
  input  logic [`MUL_OP_W-1:0] a,
  input  logic [`MUL_OP_W-1:0] b,
  output res_push_t            res
);

  localparam int PROD_W = 2 * `MUL_OP_W;

  logic              push_q;
  logic [PROD_W-1:0] product_q;

  // push follows issue by one cycle
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      push_q <= 1'b0;  // nothing pending after clear
    end else begin
      push_q <= issue;
    end
  end

  // operands are the fifo heads at the issue edge
  always_ff @(posedge clk) begin
    if (issue) begin
      product_q <= PROD_W'(a) * PROD_W'(b);  // unsigned
    end
  end

  assign res.push    = push_q;
  assign res.product = product_q;

endmodule

// File: mul_seq.sv
`timescale 1ns/1ps
`include "mul_defines.svh"

module mul_seq import mul_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  seq_ctrl_t                 ctrl,
  input  logic [`MUL_OP_CNT_W-1:0]  count_a,
  input  logic [`MUL_OP_CNT_W-1:0]  count_b,
  input  logic [`MUL_RES_CNT_W-1:0] res_count,
  input  logic                      res_inflight,
  output mul_state_e                state,
  output logic                      issue
);

  localparam int PEND_W = `MUL_RES_CNT_W + 1;
  localparam logic [`MUL_STEP_W-1:0] LAST_STEP = `MUL_STEPS - 1;
  localparam logic [PEND_W-1:0] RES_LIMIT = `MUL_RES_DEPTH;

  mul_state_e             next_state;
  logic [`MUL_STEP_W-1:0] step;
  logic [`MUL_STEP_W-1:0] next_step;
  logic [PEND_W-1:0]      res_pending;
  logic                   advance;
  logic                   ops_ready;

  // products already stored plus the one in the datapath stage
  assign res_pending = PEND_W'(res_count) + PEND_W'(res_inflight);
  assign advance     = (res_pending < RES_LIMIT);
  assign ops_ready   = (count_a != '0) && (count_b != '0);

  // pop one pair per advancing slot, none while clearing
  assign issue = (state == EXEC) && !ctrl.clear && advance && ops_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      step  <= '0;
    end else begin
      state <= next_state;
      step  <= next_step;
    end
  end

  always_comb begin
    next_state = state;
    next_step  = step;
    case (state)
      IDLE: begin
        if (ctrl.clear) begin
          next_state = IDLE;
          next_step  = '0;
        end else if (ctrl.start) begin
          next_state = EXEC;
          next_step  = '0;
        end else begin
          next_state = IDLE;  // wait for start
          next_step  = '0;
        end
      end
      EXEC: begin
        if (ctrl.clear) begin
          next_state = IDLE;
          next_step  = '0;
        end else if (!advance) begin
          next_state = EXEC;  // result fifo full, hold the slot
          next_step  = step;
        end else if (step == LAST_STEP) begin
          next_state = OUT;
          next_step  = step + 1'b1;
        end else begin
          next_state = EXEC;
          next_step  = step + 1'b1;
        end
      end
      OUT: begin
        if (ctrl.clear) begin
          next_state = IDLE;
          next_step  = '0;
        end else if (count_a == '0 && count_b == '0) begin
          next_state = DONE;  // both operand fifos drained
          next_step  = '0;
        end else begin
          next_state = IDLE;
          next_step  = '0;
        end
      end
      DONE: begin
        // clear checked first here too
        if (ctrl.clear) begin
          next_state = IDLE;
          next_step  = '0;
        end else if (ctrl.start) begin
          next_state = DONE;
          next_step  = step;
        end else begin
          next_state = IDLE;
          next_step  = '0;
        end
      end
      default: begin
        next_state = IDLE;
        next_step  = '0;
      end
    endcase
  end

endmodule

// File: fifo_sync.sv
`timescale 1ns/1ps

module fifo_sync #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push,
  input  logic [WIDTH-1:0]           wdata,
  input  logic                       pop,
  output logic [WIDTH-1:0]           rdata,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  // wrap at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;   // push on full is dropped
  assign do_pop  = pop && !empty;   // pop on empty is dropped

  assign rdata = mem[rd_ptr];  // head word, no read needed

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
    end
  end

  // registered occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

endmodule

// File: mul_pkg.sv
`include "mul_defines.svh"

package mul_pkg;

  // sequencer states, encoding kept from the original next-state block
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    EXEC = 2'd1,
    OUT  = 2'd2,
    DONE = 2'd3
  } mul_state_e;

  // one host write into an operand fifo
  typedef struct packed {
    logic                 push;  // strobe, one word per cycle
    logic [`MUL_OP_W-1:0] data;
  } op_push_t;

  // datapath output toward the result fifo
  typedef struct packed {
    logic                   push;     // one cycle per product
    logic [2*`MUL_OP_W-1:0] product;  // unsigned, full width
  } res_push_t;

  // host command levels
  typedef struct packed {
    logic start;
    logic clear;  // wins over start in every state
  } seq_ctrl_t;

endpackage

// File: mul_defines.svh
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand path
`define MUL_OP_W        32  // bits per operand word
`define MUL_OP_DEPTH    8   // words per operand fifo
`define MUL_OP_CNT_W    4   // holds 0..MUL_OP_DEPTH

// result path
`define MUL_RES_DEPTH   16  // products held for the host
`define MUL_RES_CNT_W   5   // holds 0..MUL_RES_DEPTH

// sequencer
`define MUL_STEPS       4   // exec slots per start
`define MUL_STEP_W      3   // wide enough for the value after the last slot

`endif
